// File: logic/lsab_pkg.sv
package lsab_pkg;

  // ====================
  // Widths
  // ====================
  localparam int WORD_W       = 32;
  localparam int LEN_W        = 24;
  localparam int MAX_CHANNELS = 4;
  localparam int CHAN_W       = $clog2(MAX_CHANNELS);

  typedef enum logic [2:0] {
    PUSH_SEND   = 3'd0,
    POP_RECV    = 3'd1,
    SET_CTRL    = 3'd2,
    ACK_IRQ     = 3'd3,
    ACK_ERR     = 3'd4,
    READ_STATUS = 3'd5
  } lsab_op_t;

  typedef struct packed {
    logic [5:0]       rsvd;
    logic             run;                // Fires the run strobe for one cycle
    logic             dir;
    logic [LEN_W-1:0] len;
  } lsab_ctrl_t;

  // Same word seen as send data or as a control write
  typedef union packed {
    logic [WORD_W-1:0] data;
    lsab_ctrl_t        ctrl;
  } lsab_payload_u;

  // ====================
  // CPU side
  // ====================
  typedef struct packed {
    lsab_op_t          op;
    logic [CHAN_W-1:0] chan;
    lsab_payload_u     payload;
  } lsab_cmd_t;

  typedef struct packed {
    logic [CHAN_W-1:0] chan;
    logic              empty;             // Pop hit an empty receive queue
    logic [WORD_W-1:0] data;
  } lsab_rsp_t;

  typedef struct packed {
    logic        irq;
    logic        err;
    logic        rx_ovf;
    logic        tx_ovf;
    logic [11:0] rsvd;
    logic [7:0]  rx_count;
    logic [7:0]  tx_count;
  } lsab_status_t;

  // ====================
  // Device side
  // ====================
  typedef struct packed {
    logic              wr;
    logic [WORD_W-1:0] wr_data;
    logic              rd;
    logic              irq;
    logic              err;
  } dev_in_t;

  typedef struct packed {
    logic              dvalid;
    logic [WORD_W-1:0] data;
    logic              err_ack;
    logic [LEN_W-1:0]  len;
    logic              dir;
    logic              run;
  } dev_out_t;

endpackage

// File: logic/channel_fifo.sv
`timescale 1ns/1ps

module channel_fifo
  import lsab_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic              CPU_CLK,
  input  logic              RST,
  input  logic              push,
  input  logic [WORD_W-1:0] push_data,
  input  logic              pop,
  output logic [WORD_W-1:0] pop_data,
  output logic              empty,
  output logic              full,
  output logic [7:0]        count,
  output logic              dropped
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  logic [WORD_W-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic              push_ok;
  logic              pop_ok;

  assign empty   = (count == 8'd0);
  assign full    = (count == 8'(FIFO_DEPTH));
  assign push_ok = push && !full;         // A pop in the same cycle does not make room
  assign pop_ok  = pop && !empty;
  assign dropped = push && full;

  // ====================
  // Storage
  // ====================
  always_ff @(posedge CPU_CLK)
  begin
    if (push_ok)
      mem[wr_ptr] <= push_data;
    if (pop_ok)
      pop_data <= mem[rd_ptr];             // Valid the cycle after the pop
  end

  // ====================
  // Pointers and count
  // ====================
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 8'd0;
    end
    else
    begin
      if (push_ok)
        wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 8'd1;
        2'b01:   count <= count - 8'd1;
        default: count <= count;           // Both or neither leave it unchanged
      endcase
    end
  end

  count_in_range: assert property (@(posedge CPU_CLK) disable iff (!RST)
    count <= 8'(FIFO_DEPTH))
    else $error("channel_fifo occupancy above depth");

endmodule

// File: logic/peripheral_channel.sv
`timescale 1ns/1ps

module peripheral_channel
  import lsab_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic              CPU_CLK,
  input  logic              RST,
  input  logic              push,
  input  logic              pop,
  input  logic              ctrl,
  input  logic              ack_irq,
  input  logic              ack_err,
  input  logic              status,
  input  lsab_payload_u     payload,
  input  dev_in_t           dev_in,
  output dev_out_t          dev_out,
  output logic [WORD_W-1:0] rsp_data,
  output logic              rsp_empty,
  output logic              irq
);

  logic [WORD_W-1:0] rx_pop_data;
  logic              rx_empty;
  logic [7:0]        rx_count;
  logic              rx_dropped;
  logic [WORD_W-1:0] tx_pop_data;
  logic              tx_empty;
  logic [7:0]        tx_count;
  logic              tx_dropped;

  logic              irq_q;
  logic              err_q;
  logic              rx_ovf_q;
  logic              tx_ovf_q;
  logic [LEN_W-1:0]  len_q;
  logic              dir_q;
  logic              run_q;
  logic              err_ack_q;
  logic              dvalid_q;
  logic              pop_empty_q;
  logic              status_q;
  lsab_status_t      status_now;
  lsab_status_t      status_word_q;

  // ====================
  // Queues
  // ====================
  channel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .push      (dev_in.wr),
    .push_data (dev_in.wr_data),
    .pop       (pop),
    .pop_data  (rx_pop_data),
    .empty     (rx_empty),
    .full      (),
    .count     (rx_count),
    .dropped   (rx_dropped)
  );

  channel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .push      (push),
    .push_data (payload.data),
    .pop       (dev_in.rd),
    .pop_data  (tx_pop_data),
    .empty     (tx_empty),
    .full      (),
    .count     (tx_count),
    .dropped   (tx_dropped)
  );

  always_comb
  begin
    status_now          = '0;
    status_now.irq      = irq_q;
    status_now.err      = err_q;
    status_now.rx_ovf   = rx_ovf_q;
    status_now.tx_ovf   = tx_ovf_q;
    status_now.rx_count = rx_count;
    status_now.tx_count = tx_count;
  end

  // ====================
  // Latches and control
  // ====================
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      irq_q       <= 1'b0;
      err_q       <= 1'b0;
      rx_ovf_q    <= 1'b0;
      tx_ovf_q    <= 1'b0;
      len_q       <= '0;
      dir_q       <= 1'b0;
      run_q       <= 1'b0;
      err_ack_q   <= 1'b0;
      dvalid_q    <= 1'b0;
      pop_empty_q <= 1'b0;
      status_q    <= 1'b0;
    end
    else
    begin
      irq_q       <= dev_in.irq | (irq_q & ~ack_irq);       // Set beats clear
      err_q       <= dev_in.err | (err_q & ~ack_err);
      rx_ovf_q    <= rx_dropped | (rx_ovf_q & ~status);
      tx_ovf_q    <= tx_dropped | (tx_ovf_q & ~status);
      run_q       <= ctrl & payload.ctrl.run;
      err_ack_q   <= ack_err;
      dvalid_q    <= dev_in.rd & ~tx_empty;
      pop_empty_q <= pop & rx_empty;
      status_q    <= status;
      if (ctrl)
      begin
        len_q <= payload.ctrl.len;
        dir_q <= payload.ctrl.dir;
      end
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (status)
      status_word_q <= status_now;         // Snapshot before the overflow flags clear
  end

  // ====================
  // Outputs
  // ====================
  assign rsp_data  = status_q    ? status_word_q :
                     pop_empty_q ? '0            : rx_pop_data;
  assign rsp_empty = pop_empty_q;
  assign irq       = irq_q;

  always_comb
  begin
    dev_out         = '0;
    dev_out.dvalid  = dvalid_q;
    dev_out.data    = tx_pop_data;
    dev_out.err_ack = err_ack_q;
    dev_out.len     = len_q;
    dev_out.dir     = dir_q;
    dev_out.run     = run_q;
  end

  // A run pulse ends unless another control write arrives
  run_single: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (dev_out.run && !ctrl) |=> !dev_out.run)
    else $error("peripheral_channel run held longer than one cycle");

endmodule

// File: logic/lsab_hub.sv
`timescale 1ns/1ps

module lsab_hub
  import lsab_pkg::*;
#(
  parameter int NUM_CHANNELS = 4,
  parameter int RESET_HOLD   = 64
)
(
  input  logic                    CPU_CLK,
  input  logic                    RST,
  input  logic                    cmd_valid,
  input  lsab_cmd_t               cmd,
  output logic                    rsp_valid,
  output lsab_rsp_t               rsp,
  output logic                    ready,
  output logic [NUM_CHANNELS-1:0] push,
  output logic [NUM_CHANNELS-1:0] pop,
  output logic [NUM_CHANNELS-1:0] ctrl,
  output logic [NUM_CHANNELS-1:0] ack_irq,
  output logic [NUM_CHANNELS-1:0] ack_err,
  output logic [NUM_CHANNELS-1:0] status,
  output lsab_payload_u           payload,
  input  logic [WORD_W-1:0]       chan_rsp_data [NUM_CHANNELS],
  input  logic [NUM_CHANNELS-1:0] chan_rsp_empty,
  input  logic [NUM_CHANNELS-1:0] chan_irq,
  output logic                    irq
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);

  logic [HOLD_W-1:0]       hold_cnt;
  logic                    accept;
  logic                    reply_due;
  logic [NUM_CHANNELS-1:0] chan_hot;
  logic [CHAN_W-1:0]       sel_q;

  // ====================
  // Reset hold
  // ====================
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      hold_cnt <= '0;
      ready    <= 1'b0;
    end
    else if (!ready)
    begin
      hold_cnt <= hold_cnt + 1'b1;
      if (hold_cnt == HOLD_W'(RESET_HOLD - 1))
        ready <= 1'b1;                     // Commands count from the next cycle on
    end
  end

  // ====================
  // Command decode
  // ====================
  assign accept    = cmd_valid && ready;
  assign reply_due = accept && (cmd.op == POP_RECV || cmd.op == READ_STATUS);

  always_comb
  begin
    chan_hot = '0;
    for (int i = 0; i < NUM_CHANNELS; i++)
      chan_hot[i] = accept && (cmd.chan == CHAN_W'(i));
  end

  assign push    = (cmd.op == PUSH_SEND)   ? chan_hot : '0;
  assign pop     = (cmd.op == POP_RECV)    ? chan_hot : '0;
  assign ctrl    = (cmd.op == SET_CTRL)    ? chan_hot : '0;
  assign ack_irq = (cmd.op == ACK_IRQ)     ? chan_hot : '0;
  assign ack_err = (cmd.op == ACK_ERR)     ? chan_hot : '0;
  assign status  = (cmd.op == READ_STATUS) ? chan_hot : '0;
  assign payload = cmd.payload;            // Shared by every channel, qualified by the strobes

  // ====================
  // Reply
  // ====================
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= reply_due;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
      sel_q <= cmd.chan;
  end

  always_comb
  begin
    rsp       = '0;
    rsp.chan  = sel_q;
    rsp.empty = chan_rsp_empty[sel_q];
    rsp.data  = chan_rsp_data[sel_q];
  end

  assign irq = ready & (|chan_irq);        // Stays low through the hold

  chan_in_range: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (cmd_valid && ready) |-> (int'(cmd.chan) < NUM_CHANNELS))
    else $error("lsab_hub command addressed a missing channel");

endmodule

// File: logic/chip_top.sv
`timescale 1ns/1ps

module chip_top
  import lsab_pkg::*;
#(
  parameter int NUM_CHANNELS = 4,
  parameter int FIFO_DEPTH   = 8,
  parameter int RESET_HOLD   = 64
)
(
  input  logic      CPU_CLK,
  input  logic      RST,
  input  logic      cmd_valid,
  input  lsab_cmd_t cmd,
  output logic      rsp_valid,
  output lsab_rsp_t rsp,
  output logic      ready,
  output logic      irq,
  input  dev_in_t   dev_in  [NUM_CHANNELS],
  output dev_out_t  dev_out [NUM_CHANNELS]
);

  logic [NUM_CHANNELS-1:0] push;
  logic [NUM_CHANNELS-1:0] pop;
  logic [NUM_CHANNELS-1:0] ctrl;
  logic [NUM_CHANNELS-1:0] ack_irq;
  logic [NUM_CHANNELS-1:0] ack_err;
  logic [NUM_CHANNELS-1:0] status;
  lsab_payload_u           payload;
  logic [WORD_W-1:0]       chan_rsp_data [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] chan_rsp_empty;
  logic [NUM_CHANNELS-1:0] chan_irq;

  lsab_hub #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .RESET_HOLD   (RESET_HOLD)
  ) u_hub (
    .CPU_CLK        (CPU_CLK),
    .RST            (RST),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd),
    .rsp_valid      (rsp_valid),
    .rsp            (rsp),
    .ready          (ready),
    .push           (push),
    .pop            (pop),
    .ctrl           (ctrl),
    .ack_irq        (ack_irq),
    .ack_err        (ack_err),
    .status         (status),
    .payload        (payload),
    .chan_rsp_data  (chan_rsp_data),
    .chan_rsp_empty (chan_rsp_empty),
    .chan_irq       (chan_irq),
    .irq            (irq)
  );

  // One channel per device
  for (genvar g = 0; g < NUM_CHANNELS; g++)
  begin : g_chan
    peripheral_channel #(.FIFO_DEPTH(FIFO_DEPTH)) u_chan (
      .CPU_CLK   (CPU_CLK),
      .RST       (RST),
      .push      (push[g]),
      .pop       (pop[g]),
      .ctrl      (ctrl[g]),
      .ack_irq   (ack_irq[g]),
      .ack_err   (ack_err[g]),
      .status    (status[g]),
      .payload   (payload),
      .dev_in    (dev_in[g]),
      .dev_out   (dev_out[g]),
      .rsp_data  (chan_rsp_data[g]),
      .rsp_empty (chan_rsp_empty[g]),
      .irq       (chan_irq[g])
    );
  end

endmodule

// File: bench/chip_checker.sv
`timescale 1ns/1ps

module chip_checker
  import lsab_pkg::*;
#(
  parameter int NUM_CHANNELS = 4,
  parameter int FIFO_DEPTH   = 8,
  parameter int RESET_HOLD   = 64
)
(
  input  logic      CPU_CLK,
  input  logic      RST,
  input  logic      cmd_valid,
  input  lsab_cmd_t cmd,
  input  logic      rsp_valid,
  input  lsab_rsp_t rsp,
  input  logic      ready,
  input  logic      irq,
  input  dev_in_t   dev_in  [NUM_CHANNELS],
  input  dev_out_t  dev_out [NUM_CHANNELS],
  output int        checks,
  output int        errors
);

  // ====================
  // Model state
  // ====================
  logic [WORD_W-1:0]       rx_q [NUM_CHANNELS][$];
  logic [WORD_W-1:0]       tx_q [NUM_CHANNELS][$];
  logic [NUM_CHANNELS-1:0] m_irq;
  logic [NUM_CHANNELS-1:0] m_err;
  logic [NUM_CHANNELS-1:0] m_rx_ovf;
  logic [NUM_CHANNELS-1:0] m_tx_ovf;
  logic [NUM_CHANNELS-1:0] m_run;
  logic [NUM_CHANNELS-1:0] m_err_ack;
  logic [NUM_CHANNELS-1:0] m_dvalid;
  logic [NUM_CHANNELS-1:0] m_dir;
  logic [LEN_W-1:0]        m_len    [NUM_CHANNELS];
  logic [WORD_W-1:0]       m_dvdata [NUM_CHANNELS];
  logic                    m_rsp_valid;
  lsab_rsp_t               m_rsp;
  logic                    m_ready;
  int                      hold;
  logic                    armed    = 1'b0;   // Outputs are unknown before the first reset edge
  int                      n_checks = 0;
  int                      n_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic compare_outputs();
    check_value("ready", WORD_W'(ready), WORD_W'(m_ready));
    check_value("irq", WORD_W'(irq), WORD_W'(m_ready & (|m_irq)));
    check_value("rsp_valid", WORD_W'(rsp_valid), WORD_W'(m_rsp_valid));
    if (m_rsp_valid)
    begin
      check_value("rsp.chan", WORD_W'(rsp.chan), WORD_W'(m_rsp.chan));
      check_value("rsp.empty", WORD_W'(rsp.empty), WORD_W'(m_rsp.empty));
      if (!m_rsp.empty)
        check_value("rsp.data", rsp.data, m_rsp.data);
    end
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      check_value($sformatf("dev_out[%0d].dvalid", c), WORD_W'(dev_out[c].dvalid),
                  WORD_W'(m_dvalid[c]));
      if (m_dvalid[c])
        check_value($sformatf("dev_out[%0d].data", c), dev_out[c].data, m_dvdata[c]);
      check_value($sformatf("dev_out[%0d].err_ack", c), WORD_W'(dev_out[c].err_ack),
                  WORD_W'(m_err_ack[c]));
      check_value($sformatf("dev_out[%0d].run", c), WORD_W'(dev_out[c].run),
                  WORD_W'(m_run[c]));
      check_value($sformatf("dev_out[%0d].len", c), WORD_W'(dev_out[c].len),
                  WORD_W'(m_len[c]));
      check_value($sformatf("dev_out[%0d].dir", c), WORD_W'(dev_out[c].dir),
                  WORD_W'(m_dir[c]));
    end
  endtask

  task automatic clear_model();
    armed       = 1'b1;
    m_ready     = 1'b0;
    hold        = 0;
    m_irq       = '0;
    m_err       = '0;
    m_rx_ovf    = '0;
    m_tx_ovf    = '0;
    m_run       = '0;
    m_err_ack   = '0;
    m_dvalid    = '0;
    m_dir       = '0;
    m_rsp_valid = 1'b0;
    m_rsp       = '0;
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      rx_q[c].delete();
      tx_q[c].delete();
      m_len[c]    = '0;
      m_dvdata[c] = '0;
    end
  endtask

  // One clock edge of every channel, given the inputs seen at that edge
  task automatic step_model();
    logic         accept;
    logic         sel;
    logic         was_empty;
    logic         was_full;
    lsab_status_t st;
    accept      = cmd_valid && m_ready;
    m_rsp_valid = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      sel         = accept && (int'(cmd.chan) == c);
      st          = '0;
      st.irq      = m_irq[c];
      st.err      = m_err[c];
      st.rx_ovf   = m_rx_ovf[c];
      st.tx_ovf   = m_tx_ovf[c];
      st.rx_count = 8'(rx_q[c].size());
      st.tx_count = 8'(tx_q[c].size());
      if (sel && cmd.op == READ_STATUS)
      begin
        m_rsp_valid = 1'b1;
        m_rsp.chan  = cmd.chan;
        m_rsp.empty = 1'b0;
        m_rsp.data  = st;
        m_rx_ovf[c] = 1'b0;                   // A drop in the same cycle sets it again below
        m_tx_ovf[c] = 1'b0;
      end
      was_empty = (rx_q[c].size() == 0);
      was_full  = (rx_q[c].size() == FIFO_DEPTH);
      if (sel && cmd.op == POP_RECV)
      begin
        m_rsp_valid = 1'b1;
        m_rsp.chan  = cmd.chan;
        m_rsp.empty = was_empty;
        if (!was_empty)
          m_rsp.data = rx_q[c].pop_front();
      end
      if (dev_in[c].wr)
      begin
        if (was_full)
          m_rx_ovf[c] = 1'b1;
        else
          rx_q[c].push_back(dev_in[c].wr_data);
      end
      was_empty   = (tx_q[c].size() == 0);
      was_full    = (tx_q[c].size() == FIFO_DEPTH);
      m_dvalid[c] = dev_in[c].rd && !was_empty;
      if (m_dvalid[c])
        m_dvdata[c] = tx_q[c].pop_front();
      if (sel && cmd.op == PUSH_SEND)
      begin
        if (was_full)
          m_tx_ovf[c] = 1'b1;
        else
          tx_q[c].push_back(cmd.payload.data);
      end
      m_irq[c]     = dev_in[c].irq | (m_irq[c] & !(sel && cmd.op == ACK_IRQ));
      m_err[c]     = dev_in[c].err | (m_err[c] & !(sel && cmd.op == ACK_ERR));
      m_err_ack[c] = sel && cmd.op == ACK_ERR;
      m_run[c]     = sel && cmd.op == SET_CTRL && cmd.payload.ctrl.run;
      if (sel && cmd.op == SET_CTRL)
      begin
        m_len[c] = cmd.payload.ctrl.len;
        m_dir[c] = cmd.payload.ctrl.dir;
      end
    end
    if (!m_ready)
    begin
      hold++;
      if (hold == RESET_HOLD)
        m_ready = 1'b1;
    end
  endtask

  always @(posedge CPU_CLK)
  begin
    if (armed)
      compare_outputs();
    if (!RST)
      clear_model();
    else
      step_model();
  end

endmodule

// File: bench/tb_chip.sv
`timescale 1ns/1ps

module tb_chip
  import lsab_pkg::*;
();

  localparam int NUM_CHANNELS = 4;
  localparam int FIFO_DEPTH   = 8;
  localparam int RESET_HOLD   = 64;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_CYCLES   = 4000;
  localparam int PHASE_LEN    = 128;      // Cycles between switching the traffic mix
  localparam int TIMEOUT_NS   = (RESET_CYCLES + RUN_CYCLES + 100) * CLK_PERIOD;

  logic        CPU_CLK;
  logic        RST;
  logic        cmd_valid;
  lsab_cmd_t   cmd;
  logic        rsp_valid;
  lsab_rsp_t   rsp;
  logic        ready;
  logic        irq;
  dev_in_t     dev_in  [NUM_CHANNELS];
  dev_out_t    dev_out [NUM_CHANNELS];
  int          checks;
  int          errors;
  logic [31:0] rng;

  chip_top #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .RESET_HOLD   (RESET_HOLD)
  ) UUT (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .ready     (ready),
    .irq       (irq),
    .dev_in    (dev_in),
    .dev_out   (dev_out)
  );

  chip_checker #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .RESET_HOLD   (RESET_HOLD)
  ) u_checker (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .ready     (ready),
    .irq       (irq),
    .dev_in    (dev_in),
    .dev_out   (dev_out),
    .checks    (checks),
    .errors    (errors)
  );

  initial CPU_CLK = 1'b0;
  always #(CLK_PERIOD / 2) CPU_CLK = ~CPU_CLK;

  // ====================
  // Stimulus
  // ====================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  function automatic lsab_op_t pick_op(input logic [3:0] r);
    case (r)
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4: return POP_RECV;
      4'd5, 4'd6, 4'd7, 4'd8, 4'd9: return PUSH_SEND;
      4'd10, 4'd11, 4'd12:          return READ_STATUS;
      4'd13:                        return SET_CTRL;
      4'd14:                        return ACK_IRQ;
      default:                      return ACK_ERR;
    endcase
  endfunction

  // Busy CPU phases drain receive and fill send, device phases do the opposite
  task automatic drive_cycle(input int cycle);
    logic [31:0] r;
    logic        cpu_phase;
    cpu_phase = ((cycle / PHASE_LEN) % 2) == 0;
    draw(r);
    cmd_valid = cpu_phase ? (r[1:0] != 2'b00) : (r[2:0] == 3'b000);
    cmd.op    = pick_op(r[7:4]);
    cmd.chan  = r[9:8];
    draw(r);
    cmd.payload.data = r;
    for (int c = 0; c < NUM_CHANNELS; c++)
    begin
      draw(r);
      dev_in[c].wr  = cpu_phase ? (r[4:0] == 5'd0) : (r[1:0] == 2'd0);
      dev_in[c].rd  = cpu_phase ? (r[9:5] == 5'd0) : (r[6:5] == 2'd0);
      dev_in[c].irq = (r[15:10] == 6'd0);
      dev_in[c].err = (r[21:16] == 6'd0);
      draw(r);
      dev_in[c].wr_data = r;
    end
  endtask

  task automatic go_idle();
    cmd_valid = 1'b0;
    cmd       = '0;
    for (int c = 0; c < NUM_CHANNELS; c++)
      dev_in[c] = '0;
  endtask

  task automatic report_counts();
    $display("Checks: %0d  Errors: %0d", checks, errors);
  endtask

  initial
  begin
    rng = 32'd9;
    RST = 1'b0;
    go_idle();
    repeat (RESET_CYCLES) @(negedge CPU_CLK);
    RST = 1'b1;
    for (int n = 0; n < RUN_CYCLES; n++)
    begin
      @(negedge CPU_CLK);
      drive_cycle(n);                        // Commands during the hold must be ignored
    end
    @(negedge CPU_CLK);
    go_idle();
    repeat (4) @(negedge CPU_CLK);
    report_counts();
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    report_counts();
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: flist.f
logic/lsab_pkg.sv
logic/channel_fifo.sv
logic/peripheral_channel.sv
logic/lsab_hub.sv
logic/chip_top.sv
bench/chip_checker.sv
bench/tb_chip.sv

// File: Makefile
# Verilator build and run for the channel hub testbench

VERILATOR ?= verilator
TOP       ?= tb_chip
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= TESTBENCH PASSED

SOURCES := $(filter %.sv,$(shell cat $(FLIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
